//--- compile.f
+incdir+.
gpif_reg_pkg.sv
gpif_strobe_sync.sv
gpif_reg_write.sv
gpif_reg_commit.sv
gpif_reg_read.sv
gpif_reg_list.sv
tb_gpif_reg_list.sv

//--- Bender.yml
package:
  name: gpif_reg_list

export_include_dirs:
  - .

sources:
  - gpif_reg_pkg.sv
  - gpif_strobe_sync.sv
  - gpif_reg_write.sv
  - gpif_reg_commit.sv
  - gpif_reg_read.sv
  - gpif_reg_list.sv
  - target: test
    files:
      - tb_gpif_reg_list.sv

//--- tb_gpif_reg_list.sv
// self-checking testbench for the gpif register block
// concurrent assertions compare DUT outputs against a small reference model
// model updates land only after a strobe sequence has fully settled
// strobes are held 3 cycles high and 3 cycles low
`timescale 1ns/1ns
`default_nettype none

`include "gpif_reg_params.svh"

module tb_gpif_reg_list;

	// limit far above the roughly 350 cycles of traffic
	localparam int TIMEOUT_CYCLES = 3000;

	logic                      clk_gpif = 1'b0;
	logic                      i_rst_n;
	logic                      i_wr_en;
	logic                      i_rd_en;
	logic                      i_cmd_is_rd;
	gpif_reg_pkg::addr_t       i_addr;
	gpif_reg_pkg::short_reg_t  i_wr_data;
	gpif_reg_pkg::gpif_state_t i_gpif_state;
	logic                      o_gpif_sel;
	gpif_reg_pkg::short_reg_t  o_gpif_rd_data;
	logic                      o_stream_enable;
	logic                      o_chunk_mode_active;
	gpif_reg_pkg::reg_t        o_xfer_size;
	gpif_reg_pkg::reg_t        o_xfer_count;
	gpif_reg_pkg::reg_t        o_final1_size;
	gpif_reg_pkg::reg_t        o_final2_size;
	gpif_reg_pkg::reg_t        o_payload_size;

	// ------------------------------
	// reference model
	// ------------------------------
	// indexed by decoded offset, only mapped halves are used
	gpif_reg_pkg::short_reg_t  shadow_m [0:511];
	gpif_reg_pkg::reg_t        exp_xfer_size;
	gpif_reg_pkg::reg_t        exp_xfer_count;
	gpif_reg_pkg::reg_t        exp_final1_size;
	gpif_reg_pkg::reg_t        exp_final2_size;
	gpif_reg_pkg::reg_t        exp_payload_size;
	logic                      exp_stream_en;
	logic                      exp_chunk;
	gpif_reg_pkg::gpif_state_t exp_state;
	// read expectation, valid while rd_chk is high
	logic                      exp_sel;
	gpif_reg_pkg::short_reg_t  exp_rd_data;
	logic                      rd_chk = 1'b0;
	// low while a strobe sequence is in flight
	logic                      settled = 1'b0;
	int                        cycle_cnt = 0;

	always #50 clk_gpif = ~clk_gpif;

	gpif_reg_list dut_i (
		.clk_gpif            (clk_gpif),
		.i_rst_n             (i_rst_n),
		.i_wr_en             (i_wr_en),
		.i_rd_en             (i_rd_en),
		.i_cmd_is_rd         (i_cmd_is_rd),
		.i_addr              (i_addr),
		.i_wr_data           (i_wr_data),
		.i_gpif_state        (i_gpif_state),
		.o_gpif_sel          (o_gpif_sel),
		.o_gpif_rd_data      (o_gpif_rd_data),
		.o_stream_enable     (o_stream_enable),
		.o_chunk_mode_active (o_chunk_mode_active),
		.o_xfer_size         (o_xfer_size),
		.o_xfer_count        (o_xfer_count),
		.o_final1_size       (o_final1_size),
		.o_final2_size       (o_final2_size),
		.o_payload_size      (o_payload_size)
	);

	task automatic fail_run(input string why);
		$display("%s", why);
		$display("Test failed");
		$fatal(1, "run stopped on first error");
	endtask

	task automatic report_mismatch(input string name, input logic [31:0] got,
		input logic [31:0] exp);
		fail_run($sformatf("mismatch %s: got 0x%0h expected 0x%0h", name, got, exp));
	endtask

	// ------------------------------
	// checks
	// ------------------------------
	a_xfer_size: assert property (@(posedge clk_gpif) disable iff (!i_rst_n)
		settled |-> o_xfer_size == exp_xfer_size)
		else report_mismatch("o_xfer_size", $sampled(o_xfer_size), $sampled(exp_xfer_size));
	a_xfer_count: assert property (@(posedge clk_gpif) disable iff (!i_rst_n)
		settled |-> o_xfer_count == exp_xfer_count)
		else report_mismatch("o_xfer_count", $sampled(o_xfer_count),
			$sampled(exp_xfer_count));
	a_final1: assert property (@(posedge clk_gpif) disable iff (!i_rst_n)
		settled |-> o_final1_size == exp_final1_size)
		else report_mismatch("o_final1_size", $sampled(o_final1_size),
			$sampled(exp_final1_size));
	a_final2: assert property (@(posedge clk_gpif) disable iff (!i_rst_n)
		settled |-> o_final2_size == exp_final2_size)
		else report_mismatch("o_final2_size", $sampled(o_final2_size),
			$sampled(exp_final2_size));
	a_payload: assert property (@(posedge clk_gpif) disable iff (!i_rst_n)
		settled |-> o_payload_size == exp_payload_size)
		else report_mismatch("o_payload_size", $sampled(o_payload_size),
			$sampled(exp_payload_size));
	// control bits act without a commit
	a_stream_en: assert property (@(posedge clk_gpif) disable iff (!i_rst_n)
		settled |-> o_stream_enable == exp_stream_en)
		else report_mismatch("o_stream_enable", $sampled(o_stream_enable),
			$sampled(exp_stream_en));
	a_chunk: assert property (@(posedge clk_gpif) disable iff (!i_rst_n)
		settled |-> o_chunk_mode_active == exp_chunk)
		else report_mismatch("o_chunk_mode_active", $sampled(o_chunk_mode_active),
			$sampled(exp_chunk));
	// read path, idle and active
	a_idle_sel: assert property (@(posedge clk_gpif) disable iff (!i_rst_n)
		!i_rd_en |-> !o_gpif_sel)
		else report_mismatch("o_gpif_sel", $sampled(o_gpif_sel), 0);
	a_rd_sel: assert property (@(posedge clk_gpif) disable iff (!i_rst_n)
		rd_chk |-> o_gpif_sel == exp_sel)
		else report_mismatch("o_gpif_sel", $sampled(o_gpif_sel), $sampled(exp_sel));
	a_rd_data: assert property (@(posedge clk_gpif) disable iff (!i_rst_n)
		rd_chk |-> o_gpif_rd_data == exp_rd_data)
		else report_mismatch("o_gpif_rd_data", $sampled(o_gpif_rd_data),
			$sampled(exp_rd_data));

	always @(posedge clk_gpif) begin
		cycle_cnt <= cycle_cnt + 1;
		if (cycle_cnt >= TIMEOUT_CYCLES) begin
			fail_run("timeout: the run did not finish within the cycle limit");
		end
	end

	// ------------------------------
	// model updates
	// ------------------------------
	task automatic commit_model;
		exp_xfer_size    = {shadow_m[`GPIF_OFS_XFER_SIZE_H], shadow_m[`GPIF_OFS_XFER_SIZE_L]};
		exp_xfer_count   = {shadow_m[`GPIF_OFS_XFER_COUNT_H], shadow_m[`GPIF_OFS_XFER_COUNT_L]};
		exp_final1_size  = {shadow_m[`GPIF_OFS_FINAL1_H], shadow_m[`GPIF_OFS_FINAL1_L]};
		exp_final2_size  = {shadow_m[`GPIF_OFS_FINAL2_H], shadow_m[`GPIF_OFS_FINAL2_L]};
		exp_payload_size = {shadow_m[`GPIF_OFS_PAYLOAD_H], shadow_m[`GPIF_OFS_PAYLOAD_L]};
	endtask

	task automatic apply_write(input gpif_reg_pkg::reg_ofs_t ofs,
		input gpif_reg_pkg::short_reg_t data);
		case (ofs)
			`GPIF_OFS_CFG_DONE:  if (data[0]) commit_model();
			`GPIF_OFS_STREAM_EN: exp_stream_en = data[0];
			`GPIF_OFS_CHUNK:     exp_chunk = data[0];
			default: begin
				// transfer halves and payload halves hold the full word
				if ((ofs >= `GPIF_OFS_XFER_SIZE_H && ofs <= `GPIF_OFS_FINAL2_L) ||
					ofs == `GPIF_OFS_PAYLOAD_H || ofs == `GPIF_OFS_PAYLOAD_L) begin
					shadow_m[ofs] = data;
				end
			end
		endcase
	endtask

	// ------------------------------
	// host transactions
	// ------------------------------
	task automatic write_reg(input gpif_reg_pkg::reg_ofs_t ofs,
		input gpif_reg_pkg::short_reg_t data);
		gpif_reg_pkg::addr_t addr;
		// junk in the undecoded upper bits
		addr = gpif_reg_pkg::addr_t'($urandom);
		addr[`GPIF_DEC_W-1:0] = ofs;
		settled = 1'b0;
		@(posedge clk_gpif);
		i_addr    <= addr;
		i_wr_data <= data;
		i_wr_en   <= 1'b1;
		repeat (3) @(posedge clk_gpif);
		i_wr_en <= 1'b0;
		// pulse, write and commit are all done by now
		repeat (3) @(posedge clk_gpif);
		apply_write(ofs, data);
		settled = 1'b1;
	endtask

	task automatic read_check(input gpif_reg_pkg::reg_ofs_t ofs);
		gpif_reg_pkg::addr_t addr;
		addr = gpif_reg_pkg::addr_t'($urandom);
		addr[`GPIF_DEC_W-1:0] = ofs;
		@(posedge clk_gpif);
		i_addr  <= addr;
		i_rd_en <= 1'b1;
		exp_sel     = 1'b0;
		exp_rd_data = '0;
		if (ofs >= `GPIF_OFS_XFER_SIZE_H && ofs <= `GPIF_OFS_FINAL2_L) begin
			exp_sel     = 1'b1;
			exp_rd_data = shadow_m[ofs];
		end else if (ofs == `GPIF_OFS_STATE) begin
			exp_sel     = 1'b1;
			exp_rd_data = gpif_reg_pkg::short_reg_t'(exp_state);
		end
		rd_chk = 1'b1;
		repeat (2) @(posedge clk_gpif);
		i_rd_en <= 1'b0;
		rd_chk = 1'b0;
	endtask

	// latch a random state, then move the engine on before reading back
	task automatic sample_gpif_state;
		gpif_reg_pkg::gpif_state_t st;
		st = gpif_reg_pkg::gpif_state_t'($urandom);
		@(posedge clk_gpif);
		i_gpif_state <= st;
		i_cmd_is_rd  <= 1'b1;
		repeat (3) @(posedge clk_gpif);
		i_cmd_is_rd <= 1'b0;
		repeat (3) @(posedge clk_gpif);
		exp_state = st;
		i_gpif_state <= ~st;
		read_check(`GPIF_OFS_STATE);
	endtask

	// random data into every shadow half, then read back the readable ones
	task automatic fill_shadows;
		for (int o = `GPIF_OFS_XFER_SIZE_H; o <= `GPIF_OFS_FINAL2_L; o++) begin
			write_reg(gpif_reg_pkg::reg_ofs_t'(o), gpif_reg_pkg::short_reg_t'($urandom));
		end
		write_reg(`GPIF_OFS_PAYLOAD_H, gpif_reg_pkg::short_reg_t'($urandom));
		write_reg(`GPIF_OFS_PAYLOAD_L, gpif_reg_pkg::short_reg_t'($urandom));
		for (int o = `GPIF_OFS_XFER_SIZE_H; o <= `GPIF_OFS_FINAL2_L; o++) begin
			read_check(gpif_reg_pkg::reg_ofs_t'(o));
		end
	endtask

	// ------------------------------
	// stimulus
	// ------------------------------
	initial begin
		void'($urandom(74));
		i_rst_n      <= 1'b0;
		i_wr_en      <= 1'b0;
		i_rd_en      <= 1'b0;
		i_cmd_is_rd  <= 1'b0;
		i_addr       <= '0;
		i_wr_data    <= '0;
		i_gpif_state <= '0;
		// model starts from the reset values
		foreach (shadow_m[i]) shadow_m[i] = '0;
		shadow_m[`GPIF_OFS_XFER_SIZE_H]  = `GPIF_INIT_XFER_SIZE_H;
		shadow_m[`GPIF_OFS_XFER_SIZE_L]  = `GPIF_INIT_XFER_SIZE_L;
		shadow_m[`GPIF_OFS_XFER_COUNT_H] = `GPIF_INIT_XFER_COUNT_H;
		shadow_m[`GPIF_OFS_XFER_COUNT_L] = `GPIF_INIT_XFER_COUNT_L;
		shadow_m[`GPIF_OFS_FINAL1_H]     = `GPIF_INIT_FINAL1_H;
		shadow_m[`GPIF_OFS_FINAL1_L]     = `GPIF_INIT_FINAL1_L;
		shadow_m[`GPIF_OFS_FINAL2_H]     = `GPIF_INIT_FINAL2_H;
		shadow_m[`GPIF_OFS_FINAL2_L]     = `GPIF_INIT_FINAL2_L;
		shadow_m[`GPIF_OFS_PAYLOAD_H]    = `GPIF_INIT_PAYLOAD_H;
		shadow_m[`GPIF_OFS_PAYLOAD_L]    = `GPIF_INIT_PAYLOAD_L;
		commit_model();
		exp_stream_en = 1'b0;
		exp_chunk     = 1'b0;
		exp_state     = '0;
		repeat (16) @(posedge clk_gpif);
		i_rst_n <= 1'b1;
		settled = 1'b1;

		// reset values on the read path
		for (int o = `GPIF_OFS_XFER_SIZE_H; o <= `GPIF_OFS_FINAL2_L; o++) begin
			read_check(gpif_reg_pkg::reg_ofs_t'(o));
		end
		read_check(`GPIF_OFS_STATE);

		// shadow writes, then commit, then a commit write with bit 0 clear
		fill_shadows();
		write_reg(`GPIF_OFS_CFG_DONE, 16'h0001);
		fill_shadows();
		write_reg(`GPIF_OFS_CFG_DONE, 16'hfffe);
		write_reg(`GPIF_OFS_CFG_DONE, 16'h8003);

		// immediate control bits, each set and then cleared
		write_reg(`GPIF_OFS_STREAM_EN, 16'h0001);
		write_reg(`GPIF_OFS_CHUNK, 16'hffff);
		write_reg(`GPIF_OFS_STREAM_EN, 16'h00fe);
		write_reg(`GPIF_OFS_CHUNK, 16'h7ffe);

		// state latch and unselected offsets
		repeat (3) sample_gpif_state();
		write_reg(9'h1ff, gpif_reg_pkg::short_reg_t'($urandom));
		read_check(`GPIF_OFS_PAYLOAD_H);
		read_check(`GPIF_OFS_CFG_DONE);
		read_check(`GPIF_OFS_STREAM_EN);
		read_check(9'h1ff);

		repeat (2) @(posedge clk_gpif);
		$display("Test passed");
		$finish;
	end

endmodule

`default_nettype wire

//--- gpif_reg_list.sv
// top of the gpif register block
// host strobes may be asynchronous to clk_gpif
// the host keeps address and data stable while a strobe is high
`timescale 1ns/1ns
`default_nettype none

module gpif_reg_list (
	input  wire                       clk_gpif,
	input  wire                       i_rst_n,
	input  wire                       i_wr_en,
	input  wire                       i_rd_en,
	input  wire                       i_cmd_is_rd,
	input  gpif_reg_pkg::addr_t       i_addr,
	input  gpif_reg_pkg::short_reg_t  i_wr_data,
	input  gpif_reg_pkg::gpif_state_t i_gpif_state,
	output logic                      o_gpif_sel,
	output gpif_reg_pkg::short_reg_t  o_gpif_rd_data,
	output logic                      o_stream_enable,
	output logic                      o_chunk_mode_active,
	output gpif_reg_pkg::reg_t        o_xfer_size,
	output gpif_reg_pkg::reg_t        o_xfer_count,
	output gpif_reg_pkg::reg_t        o_final1_size,
	output gpif_reg_pkg::reg_t        o_final2_size,
	output gpif_reg_pkg::reg_t        o_payload_size
);

	// ------------------------------
	// internal wires
	// ------------------------------
	logic                     wr_pulse;
	logic                     rd_cmd_pulse;
	logic                     cfg_done;
	// shadow halves
	gpif_reg_pkg::short_reg_t sh_xfer_size_h;
	gpif_reg_pkg::short_reg_t sh_xfer_size_l;
	gpif_reg_pkg::short_reg_t sh_xfer_count_h;
	gpif_reg_pkg::short_reg_t sh_xfer_count_l;
	gpif_reg_pkg::short_reg_t sh_final1_h;
	gpif_reg_pkg::short_reg_t sh_final1_l;
	gpif_reg_pkg::short_reg_t sh_final2_h;
	gpif_reg_pkg::short_reg_t sh_final2_l;
	gpif_reg_pkg::short_reg_t sh_payload_h;
	gpif_reg_pkg::short_reg_t sh_payload_l;

	// strobe edges to pulses
	gpif_strobe_sync strobe_sync_i (
		.clk_gpif       (clk_gpif),
		.i_rst_n        (i_rst_n),
		.i_wr_en        (i_wr_en),
		.i_cmd_is_rd    (i_cmd_is_rd),
		.o_wr_pulse     (wr_pulse),
		.o_rd_cmd_pulse (rd_cmd_pulse)
	);

	// decode into shadows
	gpif_reg_write reg_write_i (
		.clk_gpif            (clk_gpif),
		.i_rst_n             (i_rst_n),
		.i_wr_pulse          (wr_pulse),
		.i_addr              (i_addr),
		.i_wr_data           (i_wr_data),
		.o_cfg_done          (cfg_done),
		.o_stream_enable     (o_stream_enable),
		.o_chunk_mode_active (o_chunk_mode_active),
		.o_xfer_size_h       (sh_xfer_size_h),
		.o_xfer_size_l       (sh_xfer_size_l),
		.o_xfer_count_h      (sh_xfer_count_h),
		.o_xfer_count_l      (sh_xfer_count_l),
		.o_final1_h          (sh_final1_h),
		.o_final1_l          (sh_final1_l),
		.o_final2_h          (sh_final2_h),
		.o_final2_l          (sh_final2_l),
		.o_payload_h         (sh_payload_h),
		.o_payload_l         (sh_payload_l)
	);

	// shadows to active group
	gpif_reg_commit reg_commit_i (
		.clk_gpif       (clk_gpif),
		.i_rst_n        (i_rst_n),
		.i_cfg_done     (cfg_done),
		.i_xfer_size_h  (sh_xfer_size_h),
		.i_xfer_size_l  (sh_xfer_size_l),
		.i_xfer_count_h (sh_xfer_count_h),
		.i_xfer_count_l (sh_xfer_count_l),
		.i_final1_h     (sh_final1_h),
		.i_final1_l     (sh_final1_l),
		.i_final2_h     (sh_final2_h),
		.i_final2_l     (sh_final2_l),
		.i_payload_h    (sh_payload_h),
		.i_payload_l    (sh_payload_l),
		.o_xfer_size    (o_xfer_size),
		.o_xfer_count   (o_xfer_count),
		.o_final1_size  (o_final1_size),
		.o_final2_size  (o_final2_size),
		.o_payload_size (o_payload_size)
	);

	// read back path
	gpif_reg_read reg_read_i (
		.clk_gpif       (clk_gpif),
		.i_rst_n        (i_rst_n),
		.i_rd_en        (i_rd_en),
		.i_rd_cmd_pulse (rd_cmd_pulse),
		.i_addr         (i_addr),
		.i_gpif_state   (i_gpif_state),
		.i_xfer_size_h  (sh_xfer_size_h),
		.i_xfer_size_l  (sh_xfer_size_l),
		.i_xfer_count_h (sh_xfer_count_h),
		.i_xfer_count_l (sh_xfer_count_l),
		.i_final1_h     (sh_final1_h),
		.i_final1_l     (sh_final1_l),
		.i_final2_h     (sh_final2_h),
		.i_final2_l     (sh_final2_l),
		.o_gpif_sel     (o_gpif_sel),
		.o_gpif_rd_data (o_gpif_rd_data)
	);

endmodule

`default_nettype wire

//--- gpif_reg_read.sv
// combinational read mux and gpif state latch
// select and data follow i_rd_en and i_addr with no latency
// payload, cfg done, stream enable and chunk offsets are write only here
`timescale 1ns/1ns
`default_nettype none

`include "gpif_reg_params.svh"

module gpif_reg_read (
	input  wire                       clk_gpif,
	input  wire                       i_rst_n,
	input  wire                       i_rd_en,
	input  wire                       i_rd_cmd_pulse,
	input  gpif_reg_pkg::addr_t       i_addr,
	input  gpif_reg_pkg::gpif_state_t i_gpif_state,
	input  gpif_reg_pkg::short_reg_t  i_xfer_size_h,
	input  gpif_reg_pkg::short_reg_t  i_xfer_size_l,
	input  gpif_reg_pkg::short_reg_t  i_xfer_count_h,
	input  gpif_reg_pkg::short_reg_t  i_xfer_count_l,
	input  gpif_reg_pkg::short_reg_t  i_final1_h,
	input  gpif_reg_pkg::short_reg_t  i_final1_l,
	input  gpif_reg_pkg::short_reg_t  i_final2_h,
	input  gpif_reg_pkg::short_reg_t  i_final2_l,
	output logic                      o_gpif_sel,
	output gpif_reg_pkg::short_reg_t  o_gpif_rd_data
);

	gpif_reg_pkg::reg_ofs_t    rd_ofs;
	gpif_reg_pkg::gpif_state_t state_latch;

	assign rd_ofs = i_addr[`GPIF_DEC_W-1:0];

	// ------------------------------
	// state latch
	// ------------------------------
	// snapshot taken on each read command edge
	always_ff @(posedge clk_gpif or negedge i_rst_n) begin
		if (!i_rst_n) begin
			state_latch <= '0;
		end else if (i_rd_cmd_pulse) begin
			state_latch <= i_gpif_state;
		end
	end

	// ------------------------------
	// read mux
	// ------------------------------
	always_comb begin
		o_gpif_sel     = 1'b0;
		o_gpif_rd_data = '0;
		if (i_rd_en) begin
			// shadow values, not the active group
			o_gpif_sel = 1'b1;
			case (rd_ofs)
				`GPIF_OFS_XFER_SIZE_H:  o_gpif_rd_data = i_xfer_size_h;
				`GPIF_OFS_XFER_SIZE_L:  o_gpif_rd_data = i_xfer_size_l;
				`GPIF_OFS_XFER_COUNT_H: o_gpif_rd_data = i_xfer_count_h;
				`GPIF_OFS_XFER_COUNT_L: o_gpif_rd_data = i_xfer_count_l;
				`GPIF_OFS_FINAL1_H:     o_gpif_rd_data = i_final1_h;
				`GPIF_OFS_FINAL1_L:     o_gpif_rd_data = i_final1_l;
				`GPIF_OFS_FINAL2_H:     o_gpif_rd_data = i_final2_h;
				`GPIF_OFS_FINAL2_L:     o_gpif_rd_data = i_final2_l;
				// zero extended state
				`GPIF_OFS_STATE: begin
					o_gpif_rd_data = {{(`GPIF_SHORT_W-`GPIF_STATE_W){1'b0}}, state_latch};
				end
				// not ours, leave the bus to others
				default: o_gpif_sel = 1'b0;
			endcase
		end
	end

	// no select without an active read
	a_sel_needs_rd_en: assert property (
		@(posedge clk_gpif) disable iff (!i_rst_n)
		o_gpif_sel |-> i_rd_en
	);

endmodule

`default_nettype wire

//--- gpif_reg_commit.sv
// active register group
// all ten halves update together on the cfg done pulse
// outputs change 2 cycles after the write pulse that set cfg done
`timescale 1ns/1ns
`default_nettype none

`include "gpif_reg_params.svh"

module gpif_reg_commit (
	input  wire                      clk_gpif,
	input  wire                      i_rst_n,
	input  wire                      i_cfg_done,
	input  gpif_reg_pkg::short_reg_t i_xfer_size_h,
	input  gpif_reg_pkg::short_reg_t i_xfer_size_l,
	input  gpif_reg_pkg::short_reg_t i_xfer_count_h,
	input  gpif_reg_pkg::short_reg_t i_xfer_count_l,
	input  gpif_reg_pkg::short_reg_t i_final1_h,
	input  gpif_reg_pkg::short_reg_t i_final1_l,
	input  gpif_reg_pkg::short_reg_t i_final2_h,
	input  gpif_reg_pkg::short_reg_t i_final2_l,
	input  gpif_reg_pkg::short_reg_t i_payload_h,
	input  gpif_reg_pkg::short_reg_t i_payload_l,
	output gpif_reg_pkg::reg_t       o_xfer_size,
	output gpif_reg_pkg::reg_t       o_xfer_count,
	output gpif_reg_pkg::reg_t       o_final1_size,
	output gpif_reg_pkg::reg_t       o_final2_size,
	output gpif_reg_pkg::reg_t       o_payload_size
);

	// ------------------------------
	// active halves
	// ------------------------------
	gpif_reg_pkg::short_reg_t act_xfer_size_h;
	gpif_reg_pkg::short_reg_t act_xfer_size_l;
	gpif_reg_pkg::short_reg_t act_xfer_count_h;
	gpif_reg_pkg::short_reg_t act_xfer_count_l;
	gpif_reg_pkg::short_reg_t act_final1_h;
	gpif_reg_pkg::short_reg_t act_final1_l;
	gpif_reg_pkg::short_reg_t act_final2_h;
	gpif_reg_pkg::short_reg_t act_final2_l;
	gpif_reg_pkg::short_reg_t act_payload_h;
	gpif_reg_pkg::short_reg_t act_payload_l;

	always_ff @(posedge clk_gpif or negedge i_rst_n) begin
		if (!i_rst_n) begin
			act_xfer_size_h  <= `GPIF_INIT_XFER_SIZE_H;
			act_xfer_size_l  <= `GPIF_INIT_XFER_SIZE_L;
			act_xfer_count_h <= `GPIF_INIT_XFER_COUNT_H;
			act_xfer_count_l <= `GPIF_INIT_XFER_COUNT_L;
			act_final1_h     <= `GPIF_INIT_FINAL1_H;
			act_final1_l     <= `GPIF_INIT_FINAL1_L;
			act_final2_h     <= `GPIF_INIT_FINAL2_H;
			act_final2_l     <= `GPIF_INIT_FINAL2_L;
			act_payload_h    <= `GPIF_INIT_PAYLOAD_H;
			act_payload_l    <= `GPIF_INIT_PAYLOAD_L;
		end else if (i_cfg_done) begin
			// snapshot of every shadow at once
			act_xfer_size_h  <= i_xfer_size_h;
			act_xfer_size_l  <= i_xfer_size_l;
			act_xfer_count_h <= i_xfer_count_h;
			act_xfer_count_l <= i_xfer_count_l;
			act_final1_h     <= i_final1_h;
			act_final1_l     <= i_final1_l;
			act_final2_h     <= i_final2_h;
			act_final2_l     <= i_final2_l;
			act_payload_h    <= i_payload_h;
			act_payload_l    <= i_payload_l;
		end
	end

	// ------------------------------
	// joined outputs
	// ------------------------------
	// high half on top
	assign o_xfer_size    = {act_xfer_size_h, act_xfer_size_l};
	assign o_xfer_count   = {act_xfer_count_h, act_xfer_count_l};
	assign o_final1_size  = {act_final1_h, act_final1_l};
	assign o_final2_size  = {act_final2_h, act_final2_l};
	assign o_payload_size = {act_payload_h, act_payload_l};

	// shadow writes alone never leak into the active group
	a_active_hold: assert property (
		@(posedge clk_gpif) disable iff (!i_rst_n)
		!$past(i_cfg_done) |-> $stable({o_xfer_size, o_xfer_count, o_final1_size,
			o_final2_size, o_payload_size})
	);

endmodule

`default_nettype wire

//--- gpif_reg_write.sv
// write decoder for the shadow registers
// address and data are assumed stable while the write pulse is high
// unmapped offsets are dropped without any error flag
`timescale 1ns/1ns
`default_nettype none

`include "gpif_reg_params.svh"

module gpif_reg_write (
	input  wire                      clk_gpif,
	input  wire                      i_rst_n,
	input  wire                      i_wr_pulse,
	input  gpif_reg_pkg::addr_t      i_addr,
	input  gpif_reg_pkg::short_reg_t i_wr_data,
	output logic                     o_cfg_done,
	output logic                     o_stream_enable,
	output logic                     o_chunk_mode_active,
	output gpif_reg_pkg::short_reg_t o_xfer_size_h,
	output gpif_reg_pkg::short_reg_t o_xfer_size_l,
	output gpif_reg_pkg::short_reg_t o_xfer_count_h,
	output gpif_reg_pkg::short_reg_t o_xfer_count_l,
	output gpif_reg_pkg::short_reg_t o_final1_h,
	output gpif_reg_pkg::short_reg_t o_final1_l,
	output gpif_reg_pkg::short_reg_t o_final2_h,
	output gpif_reg_pkg::short_reg_t o_final2_l,
	output gpif_reg_pkg::short_reg_t o_payload_h,
	output gpif_reg_pkg::short_reg_t o_payload_l
);

	// upper address bits are not decoded
	gpif_reg_pkg::reg_ofs_t wr_ofs;

	assign wr_ofs = i_addr[`GPIF_DEC_W-1:0];

	// ------------------------------
	// control bits and cfg done
	// ------------------------------
	always_ff @(posedge clk_gpif or negedge i_rst_n) begin
		if (!i_rst_n) begin
			o_cfg_done          <= 1'b0;
			o_stream_enable     <= 1'b0;
			o_chunk_mode_active <= 1'b0;
		end else begin
			// cfg done is a pulse, cleared unless rewritten
			o_cfg_done <= 1'b0;
			if (i_wr_pulse) begin
				case (wr_ofs)
					`GPIF_OFS_CFG_DONE:  o_cfg_done          <= i_wr_data[0];
					// these two act at once, no commit
					`GPIF_OFS_STREAM_EN: o_stream_enable     <= i_wr_data[0];
					`GPIF_OFS_CHUNK:     o_chunk_mode_active <= i_wr_data[0];
					default: ;
				endcase
			end
		end
	end

	// ------------------------------
	// shadow halves
	// ------------------------------
	// only reach the outputs after a commit
	always_ff @(posedge clk_gpif or negedge i_rst_n) begin
		if (!i_rst_n) begin
			o_xfer_size_h  <= `GPIF_INIT_XFER_SIZE_H;
			o_xfer_size_l  <= `GPIF_INIT_XFER_SIZE_L;
			o_xfer_count_h <= `GPIF_INIT_XFER_COUNT_H;
			o_xfer_count_l <= `GPIF_INIT_XFER_COUNT_L;
			o_final1_h     <= `GPIF_INIT_FINAL1_H;
			o_final1_l     <= `GPIF_INIT_FINAL1_L;
			o_final2_h     <= `GPIF_INIT_FINAL2_H;
			o_final2_l     <= `GPIF_INIT_FINAL2_L;
			o_payload_h    <= `GPIF_INIT_PAYLOAD_H;
			o_payload_l    <= `GPIF_INIT_PAYLOAD_L;
		end else if (i_wr_pulse) begin
			case (wr_ofs)
				// transfer setup
				`GPIF_OFS_XFER_SIZE_H:  o_xfer_size_h  <= i_wr_data;
				`GPIF_OFS_XFER_SIZE_L:  o_xfer_size_l  <= i_wr_data;
				`GPIF_OFS_XFER_COUNT_H: o_xfer_count_h <= i_wr_data;
				`GPIF_OFS_XFER_COUNT_L: o_xfer_count_l <= i_wr_data;
				`GPIF_OFS_FINAL1_H:     o_final1_h     <= i_wr_data;
				`GPIF_OFS_FINAL1_L:     o_final1_l     <= i_wr_data;
				`GPIF_OFS_FINAL2_H:     o_final2_h     <= i_wr_data;
				`GPIF_OFS_FINAL2_L:     o_final2_l     <= i_wr_data;
				// payload size, write only
				`GPIF_OFS_PAYLOAD_H:    o_payload_h    <= i_wr_data;
				`GPIF_OFS_PAYLOAD_L:    o_payload_l    <= i_wr_data;
				default: ;
			endcase
		end
	end

	// pulses are 3 cycles apart at least, so cfg done never stretches
	a_cfg_done_single: assert property (
		@(posedge clk_gpif) disable iff (!i_rst_n)
		o_cfg_done |=> !o_cfg_done
	);

endmodule

`default_nettype wire

//--- gpif_strobe_sync.sv
// turns the asynchronous host strobes into one cycle pulses on clk_gpif
// only rising edges count
// strobe edges closer than 3 cycles merge into one pulse
`timescale 1ns/1ns
`default_nettype none

module gpif_strobe_sync (
	input  wire  clk_gpif,
	input  wire  i_rst_n,
	input  wire  i_wr_en,
	input  wire  i_cmd_is_rd,
	output logic o_wr_pulse,
	output logic o_rd_cmd_pulse
);

	// ------------------------------
	// sampling chains
	// ------------------------------
	// bit 0 is the newest sample
	logic [2:0] wr_en_shift;
	logic [2:0] cmd_rd_shift;

	always_ff @(posedge clk_gpif or negedge i_rst_n) begin
		if (!i_rst_n) begin
			wr_en_shift  <= 3'b000;
			cmd_rd_shift <= 3'b000;
		end else begin
			// first two stages settle the async level
			wr_en_shift  <= {wr_en_shift[1:0], i_wr_en};
			cmd_rd_shift <= {cmd_rd_shift[1:0], i_cmd_is_rd};
		end
	end

	// ------------------------------
	// edge detect
	// ------------------------------
	// two oldest bits going 0 then 1
	assign o_wr_pulse     = (wr_en_shift[2:1] == 2'b01);
	assign o_rd_cmd_pulse = (cmd_rd_shift[2:1] == 2'b01);

	// each strobe edge gives exactly one pulse cycle
	a_wr_pulse_single: assert property (
		@(posedge clk_gpif) disable iff (!i_rst_n)
		o_wr_pulse |=> !o_wr_pulse
	);

	a_rd_cmd_pulse_single: assert property (
		@(posedge clk_gpif) disable iff (!i_rst_n)
		o_rd_cmd_pulse |=> !o_rd_cmd_pulse
	);

endmodule

`default_nettype wire

//--- gpif_reg_pkg.sv
// vector types for the gpif register block
// widths come from the params header
`default_nettype none

`include "gpif_reg_params.svh"

package gpif_reg_pkg;

	// ------------------------------
	// host side
	// ------------------------------
	// full host address
	typedef logic [`GPIF_ADDR_W-1:0] addr_t;
	// decoded part of the address
	typedef logic [`GPIF_DEC_W-1:0] reg_ofs_t;

	// ------------------------------
	// register data
	// ------------------------------
	// one 16 bit half as seen by the host
	typedef logic [`GPIF_SHORT_W-1:0] short_reg_t;
	// high and low half joined
	typedef logic [`GPIF_REG_W-1:0] reg_t;

	// engine state as sampled on a read command
	typedef logic [`GPIF_STATE_W-1:0] gpif_state_t;

endpackage

`default_nettype wire

//--- gpif_reg_params.svh
// register map and reset values for the gpif register block
// only the low GPIF_DEC_W address bits are decoded
// offsets are 9 bit literals so they compare directly with the decoded offset
// reset always loads the init values below
`ifndef GPIF_REG_PARAMS_SVH
`define GPIF_REG_PARAMS_SVH

// ------------------------------
// widths
// ------------------------------
`define GPIF_ADDR_W            16
`define GPIF_DEC_W             9
`define GPIF_SHORT_W           16
`define GPIF_REG_W             32
`define GPIF_STATE_W           5

// ------------------------------
// offsets
// ------------------------------
// general control
`define GPIF_OFS_CFG_DONE      9'h020
`define GPIF_OFS_STREAM_EN     9'h030
`define GPIF_OFS_PAYLOAD_H     9'h037
`define GPIF_OFS_PAYLOAD_L     9'h038
`define GPIF_OFS_CHUNK         9'h0a0
// transfer setup, readable
`define GPIF_OFS_XFER_SIZE_H   9'h0b4
`define GPIF_OFS_XFER_SIZE_L   9'h0b5
`define GPIF_OFS_XFER_COUNT_H  9'h0b6
`define GPIF_OFS_XFER_COUNT_L  9'h0b7
`define GPIF_OFS_FINAL1_H      9'h0b8
`define GPIF_OFS_FINAL1_L      9'h0b9
`define GPIF_OFS_FINAL2_H      9'h0ba
`define GPIF_OFS_FINAL2_L      9'h0bb
// latched engine state, read only
`define GPIF_OFS_STATE         9'h0c0

// ------------------------------
// reset values, one per half
// ------------------------------
`define GPIF_INIT_XFER_SIZE_H  16'h0010
`define GPIF_INIT_XFER_SIZE_L  16'h0000
`define GPIF_INIT_XFER_COUNT_H 16'h0000
`define GPIF_INIT_XFER_COUNT_L 16'h0004
`define GPIF_INIT_FINAL1_H     16'h000c
`define GPIF_INIT_FINAL1_L     16'he000
`define GPIF_INIT_FINAL2_H     16'h0000
`define GPIF_INIT_FINAL2_L     16'h0400
`define GPIF_INIT_PAYLOAD_H    16'h004c
`define GPIF_INIT_PAYLOAD_L    16'he300

`endif
